// File: source/rv32i_pkg.sv
package rv32i_pkg;

    typedef logic [31:0] rv32i_word;

    // Major opcodes that the core decodes. Anything else retires as a no-op.
    typedef enum logic [6:0] {
        op_imm = 7'b0010011,
        op_reg = 7'b0110011,
        lui    = 7'b0110111,
        auipc  = 7'b0010111,
        load   = 7'b0000011,
        store  = 7'b0100011
    } opcode_t;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and
    } alu_op_t;

    typedef enum logic [2:0] {
        lb  = 3'b000,
        lh  = 3'b001,
        lw  = 3'b010,
        lbu = 3'b100,
        lhu = 3'b101
    } load_funct3_t;

    typedef enum logic [2:0] {
        sb = 3'b000,
        sh = 3'b001,
        sw = 3'b010
    } store_funct3_t;

    typedef enum logic {
        idle,
        wait_ack
    } fetch_state_t;

    typedef enum logic {
        run,
        mem_wait
    } exec_state_t;

endpackage : rv32i_pkg

// File: source/inst_stream_if.sv
`timescale 1ns/1ps

// A word moves when valid and ready are both high.
interface inst_stream_if;

    logic                 valid;
    logic                 ready;
    rv32i_pkg::rv32i_word pc;
    rv32i_pkg::rv32i_word ir;

    modport source (
        output valid,
        output pc,
        output ir,
        input  ready
    );

    modport sink (
        input  valid,
        input  pc,
        input  ir,
        output ready
    );

endinterface : inst_stream_if

// File: source/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit #(
    parameter rv32i_pkg::rv32i_word RESET_PC = 32'h0000_0000
) (
    input  logic                 clk,
    input  logic                 rst_i,

    output rv32i_pkg::rv32i_word imem_adr_o,
    output logic                 imem_cyc_o,
    output logic                 imem_stb_o,
    input  rv32i_pkg::rv32i_word imem_dat_i,
    input  logic                 imem_ack_i,

    inst_stream_if.source        stream_o
);

    rv32i_pkg::fetch_state_t state_q;
    rv32i_pkg::rv32i_word    pc_q;
    rv32i_pkg::rv32i_word    ir_q;
    logic                    word_valid_q;
    logic                    moved;

    assign moved = stream_o.valid && stream_o.ready;

    // The program counter doubles as the address of the held word.
    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q      <= rv32i_pkg::idle;
            pc_q         <= RESET_PC;
            word_valid_q <= 1'b0;
        end else begin
            case (state_q)
                rv32i_pkg::idle: begin
                    if (!word_valid_q || moved)
                        state_q <= rv32i_pkg::wait_ack;
                end
                rv32i_pkg::wait_ack: begin
                    if (imem_ack_i) begin
                        state_q      <= rv32i_pkg::idle; // Bus drops the cycle after ack.
                        word_valid_q <= 1'b1;
                    end
                end
                default: state_q <= rv32i_pkg::idle;
            endcase
            if (moved) begin
                word_valid_q <= 1'b0;
                pc_q         <= pc_q + 32'd4;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == rv32i_pkg::wait_ack && imem_ack_i)
            ir_q <= imem_dat_i;
    end

    assign imem_adr_o     = pc_q;
    assign imem_cyc_o     = (state_q == rv32i_pkg::wait_ack);
    assign imem_stb_o     = (state_q == rv32i_pkg::wait_ack);

    assign stream_o.valid = word_valid_q;
    assign stream_o.pc    = pc_q;
    assign stream_o.ir    = ir_q;

endmodule : fetch_unit

// File: source/inst_queue.sv
`timescale 1ns/1ps

module inst_queue #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic          clk,
    input  logic          rst_i,

    inst_stream_if.sink   push_i,
    inst_stream_if.source pop_o
);

    localparam int IDX_W = $clog2(QUEUE_DEPTH);

    rv32i_pkg::rv32i_word pc_mem [QUEUE_DEPTH];
    rv32i_pkg::rv32i_word ir_mem [QUEUE_DEPTH];

    // One extra pointer bit tells a full queue from an empty one.
    logic [IDX_W:0] wr_ptr_q;
    logic [IDX_W:0] rd_ptr_q;
    logic           full;
    logic           empty;
    logic           do_push;
    logic           do_pop;

    assign empty = (wr_ptr_q == rd_ptr_q);
    assign full  = (wr_ptr_q[IDX_W] != rd_ptr_q[IDX_W]) &&
                   (wr_ptr_q[IDX_W-1:0] == rd_ptr_q[IDX_W-1:0]);

    assign do_push = push_i.valid && push_i.ready;
    assign do_pop  = pop_o.valid && pop_o.ready;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
        end else begin
            if (do_push)
                wr_ptr_q <= wr_ptr_q + 1'b1;
            if (do_pop)
                rd_ptr_q <= rd_ptr_q + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            pc_mem[wr_ptr_q[IDX_W-1:0]] <= push_i.pc;
            ir_mem[wr_ptr_q[IDX_W-1:0]] <= push_i.ir;
        end
    end

    assign push_i.ready = !full;
    assign pop_o.valid  = !empty; // Head is visible the cycle after its push.
    assign pop_o.pc     = pc_mem[rd_ptr_q[IDX_W-1:0]];
    assign pop_o.ir     = ir_mem[rd_ptr_q[IDX_W-1:0]];

endmodule : inst_queue

// File: source/execute_unit.sv
`timescale 1ns/1ps

module execute_unit (
    input  logic                 clk,
    input  logic                 rst_i,

    inst_stream_if.sink          inst_i,

    output rv32i_pkg::rv32i_word dmem_adr_o,
    output rv32i_pkg::rv32i_word dmem_dat_o,
    output logic [3:0]           dmem_sel_o,
    output logic                 dmem_we_o,
    output logic                 dmem_cyc_o,
    output logic                 dmem_stb_o,
    input  rv32i_pkg::rv32i_word dmem_dat_i,
    input  logic                 dmem_ack_i
);

    rv32i_pkg::rv32i_word    regs [32];
    rv32i_pkg::exec_state_t  state_q;
    rv32i_pkg::opcode_t      opcode;
    rv32i_pkg::alu_op_t      alu_op;
    logic [2:0]              funct3;
    logic [6:0]              funct7;
    logic [4:0]              rs1, rs2, rd;
    rv32i_pkg::rv32i_word    i_imm, s_imm, u_imm;
    rv32i_pkg::rv32i_word    rs1_val, rs2_val, alu_b, alu_res;
    rv32i_pkg::rv32i_word    eff_addr, store_data, load_data, wr_data;
    logic [3:0]              store_sel;
    logic                    accept, is_mem, wr_en;
    logic [4:0]              wr_addr;

    // Held for the whole data-bus cycle.
    rv32i_pkg::rv32i_word    addr_q, wdata_q;
    logic [3:0]              sel_q;
    logic                    we_q;
    logic [4:0]              rd_q;
    logic [2:0]              funct3_q;

    assign opcode = rv32i_pkg::opcode_t'(inst_i.ir[6:0]);
    assign rd     = inst_i.ir[11:7];
    assign funct3 = inst_i.ir[14:12];
    assign rs1    = inst_i.ir[19:15];
    assign rs2    = inst_i.ir[24:20];
    assign funct7 = inst_i.ir[31:25];
    assign i_imm  = {{20{inst_i.ir[31]}}, inst_i.ir[31:20]};
    assign s_imm  = {{20{inst_i.ir[31]}}, inst_i.ir[31:25], inst_i.ir[11:7]};
    assign u_imm  = {inst_i.ir[31:12], 12'h000};

    assign rs1_val = (rs1 == 5'd0) ? '0 : regs[rs1];
    assign rs2_val = (rs2 == 5'd0) ? '0 : regs[rs2];

    assign accept   = inst_i.valid && inst_i.ready;
    assign is_mem   = (opcode == rv32i_pkg::load) || (opcode == rv32i_pkg::store);
    assign alu_b    = (opcode == rv32i_pkg::op_reg) ? rs2_val : i_imm;
    assign eff_addr = rs1_val + ((opcode == rv32i_pkg::store) ? s_imm : i_imm);

    always_comb begin
        case (funct3)
            3'b000: alu_op = (opcode == rv32i_pkg::op_reg && funct7[5]) ?
                             rv32i_pkg::alu_sub : rv32i_pkg::alu_add;
            3'b001: alu_op = rv32i_pkg::alu_sll;
            3'b010: alu_op = rv32i_pkg::alu_slt;
            3'b011: alu_op = rv32i_pkg::alu_sltu;
            3'b100: alu_op = rv32i_pkg::alu_xor;
            3'b101: alu_op = funct7[5] ? rv32i_pkg::alu_sra : rv32i_pkg::alu_srl;
            3'b110: alu_op = rv32i_pkg::alu_or;
            default: alu_op = rv32i_pkg::alu_and;
        endcase
    end

    always_comb begin
        case (alu_op)
            rv32i_pkg::alu_add:  alu_res = rs1_val + alu_b;
            rv32i_pkg::alu_sub:  alu_res = rs1_val - alu_b;
            rv32i_pkg::alu_sll:  alu_res = rs1_val << alu_b[4:0];
            rv32i_pkg::alu_slt:  alu_res = {31'b0, $signed(rs1_val) < $signed(alu_b)};
            rv32i_pkg::alu_sltu: alu_res = {31'b0, rs1_val < alu_b};
            rv32i_pkg::alu_xor:  alu_res = rs1_val ^ alu_b;
            rv32i_pkg::alu_srl:  alu_res = rs1_val >> alu_b[4:0];
            rv32i_pkg::alu_sra:  alu_res = $signed(rs1_val) >>> alu_b[4:0];
            rv32i_pkg::alu_or:   alu_res = rs1_val | alu_b;
            default:             alu_res = rs1_val & alu_b;
        endcase
    end

    // Store data moves to the byte lane picked by the low address bits.
    always_comb begin
        case (rv32i_pkg::store_funct3_t'(funct3))
            rv32i_pkg::sh: begin
                store_data = eff_addr[1] ? rs2_val << 16 : rs2_val;
                store_sel  = eff_addr[1] ? 4'b1100 : 4'b0011;
            end
            rv32i_pkg::sb: begin
                store_data = rs2_val << {eff_addr[1:0], 3'b000};
                store_sel  = 4'b0001 << eff_addr[1:0];
            end
            default: begin
                store_data = rs2_val;
                store_sel  = 4'b1111;
            end
        endcase
    end

    always_comb begin
        case (rv32i_pkg::load_funct3_t'(funct3_q))
            rv32i_pkg::lb:
                case (addr_q[1:0])
                    2'b00: load_data = {{24{dmem_dat_i[7]}}, dmem_dat_i[7:0]};
                    2'b01: load_data = {{24{dmem_dat_i[15]}}, dmem_dat_i[15:8]};
                    2'b10: load_data = {{24{dmem_dat_i[23]}}, dmem_dat_i[23:16]};
                    default: load_data = {{24{dmem_dat_i[31]}}, dmem_dat_i[31:24]};
                endcase
            rv32i_pkg::lbu:
                case (addr_q[1:0])
                    2'b00: load_data = {24'b0, dmem_dat_i[7:0]};
                    2'b01: load_data = {24'b0, dmem_dat_i[15:8]};
                    2'b10: load_data = {24'b0, dmem_dat_i[23:16]};
                    default: load_data = {24'b0, dmem_dat_i[31:24]};
                endcase
            rv32i_pkg::lh: load_data = addr_q[1] ?
                                       {{16{dmem_dat_i[31]}}, dmem_dat_i[31:16]} :
                                       {{16{dmem_dat_i[15]}}, dmem_dat_i[15:0]};
            rv32i_pkg::lhu: load_data = addr_q[1] ? {16'b0, dmem_dat_i[31:16]} :
                                                    {16'b0, dmem_dat_i[15:0]};
            default: load_data = dmem_dat_i;
        endcase
    end

    always_comb begin
        wr_en   = 1'b0;
        wr_addr = rd;
        wr_data = alu_res;
        if (accept) begin
            case (opcode)
                rv32i_pkg::op_imm, rv32i_pkg::op_reg: wr_en = 1'b1;
                rv32i_pkg::lui: begin
                    wr_en   = 1'b1;
                    wr_data = u_imm;
                end
                rv32i_pkg::auipc: begin
                    wr_en   = 1'b1;
                    wr_data = inst_i.pc + u_imm;
                end
                default: wr_en = 1'b0; // Memory ops write later, others are no-ops.
            endcase
        end else if (state_q == rv32i_pkg::mem_wait && dmem_ack_i && !we_q) begin
            wr_en   = 1'b1;
            wr_addr = rd_q;
            wr_data = load_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end else if (wr_en && wr_addr != 5'd0) begin
            regs[wr_addr] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q <= rv32i_pkg::run;
            we_q    <= 1'b0;
        end else if (state_q == rv32i_pkg::run) begin
            if (accept && is_mem) begin
                state_q <= rv32i_pkg::mem_wait;
                we_q    <= (opcode == rv32i_pkg::store);
            end
        end else if (dmem_ack_i) begin
            state_q <= rv32i_pkg::run;
        end
    end

    always_ff @(posedge clk) begin
        if (accept && is_mem) begin
            addr_q   <= eff_addr;
            wdata_q  <= store_data;
            sel_q    <= (opcode == rv32i_pkg::store) ? store_sel : 4'b1111;
            rd_q     <= rd;
            funct3_q <= funct3;
        end
    end

    assign inst_i.ready = (state_q == rv32i_pkg::run);

    assign dmem_adr_o = addr_q;
    assign dmem_dat_o = wdata_q;
    assign dmem_sel_o = sel_q;
    assign dmem_we_o  = we_q;
    assign dmem_cyc_o = (state_q == rv32i_pkg::mem_wait);
    assign dmem_stb_o = (state_q == rv32i_pkg::mem_wait);

endmodule : execute_unit

// File: source/rv32i_core.sv
`timescale 1ns/1ps

module rv32i_core #(
    parameter rv32i_pkg::rv32i_word RESET_PC    = 32'h0000_0000,
    parameter int                   QUEUE_DEPTH = 4
) (
    input  logic                 clk,
    input  logic                 rst_i,

    // Instruction bus, read only.
    output rv32i_pkg::rv32i_word imem_adr_o,
    output logic                 imem_cyc_o,
    output logic                 imem_stb_o,
    input  rv32i_pkg::rv32i_word imem_dat_i,
    input  logic                 imem_ack_i,

    // Data bus.
    output rv32i_pkg::rv32i_word dmem_adr_o,
    output rv32i_pkg::rv32i_word dmem_dat_o,
    output logic [3:0]           dmem_sel_o,
    output logic                 dmem_we_o,
    output logic                 dmem_cyc_o,
    output logic                 dmem_stb_o,
    input  rv32i_pkg::rv32i_word dmem_dat_i,
    input  logic                 dmem_ack_i
);

    inst_stream_if fetch_to_queue ();
    inst_stream_if queue_to_exec ();

    fetch_unit #(
        .RESET_PC (RESET_PC)
    ) u_fetch (
        .clk        (clk),
        .rst_i      (rst_i),
        .imem_adr_o (imem_adr_o),
        .imem_cyc_o (imem_cyc_o),
        .imem_stb_o (imem_stb_o),
        .imem_dat_i (imem_dat_i),
        .imem_ack_i (imem_ack_i),
        .stream_o   (fetch_to_queue.source)
    );

    inst_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) u_queue (
        .clk    (clk),
        .rst_i  (rst_i),
        .push_i (fetch_to_queue.sink),
        .pop_o  (queue_to_exec.source)
    );

    execute_unit u_exec (
        .clk        (clk),
        .rst_i      (rst_i),
        .inst_i     (queue_to_exec.sink),
        .dmem_adr_o (dmem_adr_o),
        .dmem_dat_o (dmem_dat_o),
        .dmem_sel_o (dmem_sel_o),
        .dmem_we_o  (dmem_we_o),
        .dmem_cyc_o (dmem_cyc_o),
        .dmem_stb_o (dmem_stb_o),
        .dmem_dat_i (dmem_dat_i),
        .dmem_ack_i (dmem_ack_i)
    );

endmodule : rv32i_core

// File: test/core_sva.sv
`timescale 1ns/1ps

module core_sva (
    input logic        clk,
    input logic        rst_i,
    input logic [31:0] imem_adr_i,
    input logic        imem_cyc_i,
    input logic        imem_stb_i,
    input logic        imem_ack_i,
    input logic [31:0] dmem_adr_i,
    input logic [31:0] dmem_wdat_i,
    input logic [3:0]  dmem_sel_i,
    input logic        dmem_we_i,
    input logic        dmem_cyc_i,
    input logic        dmem_stb_i,
    input logic        dmem_ack_i
);

    imem_stb_in_cyc: assert property (@(posedge clk) disable iff (rst_i)
        imem_stb_i |-> imem_cyc_i) else $error("imem stb raised without cyc");

    dmem_stb_in_cyc: assert property (@(posedge clk) disable iff (rst_i)
        dmem_stb_i |-> dmem_cyc_i) else $error("dmem stb raised without cyc");

    // A waiting master keeps its request unchanged.
    imem_req_stable: assert property (@(posedge clk) disable iff (rst_i)
        (imem_stb_i && !imem_ack_i) |=> $stable(imem_adr_i))
        else $error("imem address changed before ack");

    dmem_req_stable: assert property (@(posedge clk) disable iff (rst_i)
        (dmem_stb_i && !dmem_ack_i) |=> $stable({dmem_adr_i, dmem_wdat_i, dmem_sel_i, dmem_we_i}))
        else $error("dmem request changed before ack");

    imem_drop_after_ack: assert property (@(posedge clk) disable iff (rst_i)
        imem_ack_i |=> !imem_stb_i) else $error("imem stb still high after ack");

    dmem_drop_after_ack: assert property (@(posedge clk) disable iff (rst_i)
        dmem_ack_i |=> !dmem_stb_i) else $error("dmem stb still high after ack");

endmodule : core_sva

bind rv32i_core core_sva u_core_sva (
    .clk         (clk),
    .rst_i       (rst_i),
    .imem_adr_i  (imem_adr_o),
    .imem_cyc_i  (imem_cyc_o),
    .imem_stb_i  (imem_stb_o),
    .imem_ack_i  (imem_ack_i),
    .dmem_adr_i  (dmem_adr_o),
    .dmem_wdat_i (dmem_dat_o),
    .dmem_sel_i  (dmem_sel_o),
    .dmem_we_i   (dmem_we_o),
    .dmem_cyc_i  (dmem_cyc_o),
    .dmem_stb_i  (dmem_stb_o),
    .dmem_ack_i  (dmem_ack_i)
);

// File: test/tb_core.sv
`timescale 1ns/1ps

module tb_core;

    localparam logic [31:0] RESET_PC   = 32'h0000_0080;
    localparam int          DMEM_BYTES = 4096;
    localparam logic [31:0] NOP        = 32'h0000_0013;
    localparam logic [6:0]  OP_IMM     = 7'h13;
    localparam logic [6:0]  OP_REG     = 7'h33;
    localparam logic [6:0]  LUI_OP     = 7'h37;
    localparam logic [6:0]  AUIPC_OP   = 7'h17;
    localparam logic [6:0]  LOAD_OP    = 7'h03;
    localparam logic [6:0]  STORE_OP   = 7'h23;

    logic        clk;
    logic        rst_i;
    logic [31:0] imem_adr_o;
    logic        imem_cyc_o;
    logic        imem_stb_o;
    logic [31:0] imem_dat_i;
    logic        imem_ack_i;
    logic [31:0] dmem_adr_o;
    logic [31:0] dmem_dat_o;
    logic [3:0]  dmem_sel_o;
    logic        dmem_we_o;
    logic        dmem_cyc_o;
    logic        dmem_stb_o;
    logic [31:0] dmem_dat_i;
    logic        dmem_ack_i;

    logic [31:0] prog [$];
    logic [31:0] exp_addr [$];
    logic [3:0]  exp_sel [$];
    logic [31:0] exp_data [$];
    logic [7:0]  dmem [DMEM_BYTES];
    logic [31:0] idx;
    logic [31:0] mask;
    logic [11:0] base;
    int          iwait = 0;
    int          dwait = 0;
    bit          first_fetch_seen = 1'b0;
    int          errors = 0;
    int          checked = 0;
    int          cycles = 0;
    int          limit;

    rv32i_core #(
        .RESET_PC    (RESET_PC),
        .QUEUE_DEPTH (4)
    ) uut (.*);

    always #5 clk = ~clk;

    function automatic logic [31:0] itype(input logic [6:0] op, input int rd, f3, rs1, imm);
        return {12'(imm), 5'(rs1), 3'(f3), 5'(rd), op};
    endfunction

    function automatic logic [31:0] rtype(input int f7, rs2, rs1, f3, rd);
        return {7'(f7), 5'(rs2), 5'(rs1), 3'(f3), 5'(rd), OP_REG};
    endfunction

    function automatic logic [31:0] stype(input int f3, rs2, rs1, imm);
        logic [11:0] i12;
        i12 = 12'(imm);
        return {i12[11:5], 5'(rs2), 5'(rs1), 3'(f3), i12[4:0], STORE_OP};
    endfunction

    function automatic logic [31:0] utype(input logic [6:0] op, input int rd, imm);
        return {20'(imm), 5'(rd), op};
    endfunction

    // Initial data memory contents, mixed from all twelve address bits.
    function automatic logic [7:0] fill_byte(input int a);
        return 8'(a) ^ 8'(a >> 8) ^ 8'h5a;
    endfunction

    function automatic logic [31:0] lane_mask(input logic [3:0] sel);
        return {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
    endfunction

    function automatic void build_program();
        int slot;
        slot = 0;
        prog.push_back(itype(OP_IMM, 1, 0, 0, 'h100)); // Data base address.
        prog.push_back(itype(OP_IMM, 2, 0, 0, -5));
        prog.push_back(itype(OP_IMM, 3, 0, 0, 1234));
        prog.push_back(itype(OP_IMM, 4, 2, 2, 3));
        prog.push_back(itype(OP_IMM, 5, 3, 2, 3));
        prog.push_back(itype(OP_IMM, 6, 4, 3, 'h5a5));
        prog.push_back(itype(OP_IMM, 7, 6, 3, -256));
        prog.push_back(itype(OP_IMM, 8, 7, 3, 'h0f0));
        prog.push_back(itype(OP_IMM, 9, 1, 3, 7));
        prog.push_back(itype(OP_IMM, 10, 5, 2, 4));
        prog.push_back(itype(OP_IMM, 11, 5, 2, 'h402)); // SRAI by two.
        prog.push_back(rtype(0, 3, 2, 0, 12));
        prog.push_back(rtype('h20, 3, 2, 0, 13));
        prog.push_back(rtype(0, 2, 3, 1, 14));
        prog.push_back(rtype(0, 3, 2, 2, 15));
        prog.push_back(rtype(0, 3, 2, 3, 16));
        prog.push_back(rtype(0, 3, 2, 4, 17));
        prog.push_back(rtype(0, 3, 2, 5, 18));
        prog.push_back(rtype('h20, 3, 2, 5, 19));
        prog.push_back(rtype(0, 9, 6, 6, 20));
        prog.push_back(rtype(0, 13, 7, 7, 21));
        prog.push_back(utype(LUI_OP, 22, 'hdeadb));
        prog.push_back(utype(AUIPC_OP, 23, 'h12345));
        for (int r = 2; r <= 23; r++)
            prog.push_back(stype(2, r, 1, 4 * (r - 2)));
        // Known word 0x8f7e65d4 at 0x200 for the load tests.
        prog.push_back(utype(LUI_OP, 24, 'h8f7e6));
        prog.push_back(itype(OP_IMM, 24, 0, 24, 'h5d4));
        prog.push_back(stype(2, 24, 1, 'h100));
        for (int off = 0; off < 4; off++) begin
            for (int u = 0; u < 2; u++) begin
                prog.push_back(itype(LOAD_OP, 25, u * 4, 1, 'h100 + off)); // LB, then LBU.
                prog.push_back(stype(2, 25, 1, 'h300 + 4 * slot));
                slot++;
            end
        end
        for (int off = 0; off < 4; off += 2) begin
            for (int u = 0; u < 2; u++) begin
                prog.push_back(itype(LOAD_OP, 25, 1 + u * 4, 1, 'h100 + off)); // LH, then LHU.
                prog.push_back(stype(2, 25, 1, 'h300 + 4 * slot));
                slot++;
            end
        end
        prog.push_back(stype(1, 3, 1, 'h200));
        prog.push_back(stype(1, 3, 1, 'h202));
        for (int off = 0; off < 4; off++)
            prog.push_back(stype(0, 6 + off, 1, 'h204 + off));
        prog.push_back(itype(LOAD_OP, 26, 2, 1, 'h200));
        prog.push_back(stype(2, 26, 1, 'h280));
        prog.push_back(itype(LOAD_OP, 27, 2, 1, 'h204));
        prog.push_back(stype(2, 27, 1, 'h284));
    endfunction

    // Instruction-level model of the program, listing every store it makes.
    function automatic void run_reference();
        logic [31:0] r [32];
        logic [7:0]  mem [DMEM_BYTES];
        logic [31:0] ir, pc, a, b, res, addr, sdat, imm_i, imm_s, imm_u;
        logic [3:0]  sel;
        logic [2:0]  f3;
        logic [1:0]  kb, lane;
        logic        wr;
        int          n;
        for (int i = 0; i < 32; i++)
            r[i] = '0;
        for (int i = 0; i < DMEM_BYTES; i++)
            mem[i] = fill_byte(i);
        for (int i = 0; i < prog.size(); i++) begin
            ir    = prog[i];
            pc    = RESET_PC + 32'(4 * i);
            f3    = ir[14:12];
            a     = r[ir[19:15]];
            b     = r[ir[24:20]];
            imm_i = {{20{ir[31]}}, ir[31:20]};
            imm_s = {{20{ir[31]}}, ir[31:25], ir[11:7]};
            imm_u = {ir[31:12], 12'h000};
            wr    = 1'b1;
            res   = '0;
            case (ir[6:0])
                OP_IMM, OP_REG: begin
                    if (ir[6:0] == OP_IMM)
                        b = imm_i;
                    case (f3)
                        3'd0: res = (ir[6:0] == OP_REG && ir[30]) ? a - b : a + b;
                        3'd1: res = a << b[4:0];
                        3'd2: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        3'd3: res = (a < b) ? 32'd1 : 32'd0;
                        3'd4: res = a ^ b;
                        3'd5: begin
                            if (ir[30])
                                res = $signed(a) >>> b[4:0];
                            else
                                res = a >> b[4:0];
                        end
                        3'd6: res = a | b;
                        default: res = a & b;
                    endcase
                end
                LUI_OP: res = imm_u;
                AUIPC_OP: res = pc + imm_u;
                LOAD_OP: begin
                    addr = a + imm_i;
                    res  = {mem[12'(addr + 3)], mem[12'(addr + 2)],
                            mem[12'(addr + 1)], mem[12'(addr)]};
                    case (f3)
                        3'd0: res = {{24{res[7]}}, res[7:0]};
                        3'd1: res = {{16{res[15]}}, res[15:0]};
                        3'd4: res = {24'h0, res[7:0]};
                        3'd5: res = {16'h0, res[15:0]};
                        default: res = res;
                    endcase
                end
                STORE_OP: begin
                    wr   = 1'b0;
                    addr = a + imm_s;
                    n    = (f3 == 3'd0) ? 1 : (f3 == 3'd1) ? 2 : 4;
                    sel  = '0;
                    sdat = '0;
                    for (int k = 0; k < n; k++) begin
                        kb   = 2'(k);
                        lane = addr[1:0] + kb; // Byte k of rs2 lands in its own lane.
                        mem[12'(addr + 32'(k))]   = b[{kb, 3'b000} +: 8];
                        sel[lane]                 = 1'b1;
                        sdat[{lane, 3'b000} +: 8] = b[{kb, 3'b000} +: 8];
                    end
                    exp_addr.push_back(addr);
                    exp_sel.push_back(sel);
                    exp_data.push_back(sdat);
                end
                default: wr = 1'b0;
            endcase
            if (wr && ir[11:7] != 5'd0)
                r[ir[11:7]] = res;
        end
    endfunction

    // Instruction memory with 0 to 3 wait states per request.
    always @(negedge clk) begin
        if (imem_ack_i) begin
            imem_ack_i = 1'b0;
        end else if (imem_cyc_o && imem_stb_o) begin
            if (!first_fetch_seen) begin
                first_fetch_seen = 1'b1;
                if (imem_adr_o !== RESET_PC) begin
                    errors++;
                    $display("ERROR at %0t ns: first fetch address %h, expected %h",
                             $time, imem_adr_o, RESET_PC);
                end
            end
            if (iwait != 0) begin
                iwait--;
            end else begin
                idx        = (imem_adr_o - RESET_PC) >> 2;
                imem_dat_i = (idx < 32'(prog.size())) ? prog[idx] : NOP;
                imem_ack_i = 1'b1;
                iwait      = $urandom_range(0, 3);
            end
        end
    end

    // Data memory. Its long waits back the queue up into fetch.
    always @(negedge clk) begin
        if (dmem_ack_i) begin
            dmem_ack_i = 1'b0;
        end else if (dmem_cyc_o && dmem_stb_o) begin
            if (dwait != 0) begin
                dwait--;
            end else begin
                base = {dmem_adr_o[11:2], 2'b00};
                if (dmem_we_o) begin
                    if (dmem_sel_o[0]) dmem[base]          = dmem_dat_o[7:0];
                    if (dmem_sel_o[1]) dmem[base + 12'd1]  = dmem_dat_o[15:8];
                    if (dmem_sel_o[2]) dmem[base + 12'd2]  = dmem_dat_o[23:16];
                    if (dmem_sel_o[3]) dmem[base + 12'd3]  = dmem_dat_o[31:24];
                end else begin
                    dmem_dat_i = {dmem[base + 12'd3], dmem[base + 12'd2],
                                  dmem[base + 12'd1], dmem[base]};
                end
                dmem_ack_i = 1'b1;
                dwait      = $urandom_range(0, 12);
            end
        end
    end

    // Store checker, woken by each data-bus ack while the master still holds the bus.
    always @(posedge dmem_ack_i) begin
        if (dmem_we_o) begin
            if (checked >= exp_addr.size()) begin
                errors++;
                $display("ERROR at %0t ns: unexpected store to %h", $time, dmem_adr_o);
            end else begin
                mask = lane_mask(exp_sel[checked]);
                if (dmem_adr_o !== exp_addr[checked] || dmem_sel_o !== exp_sel[checked] ||
                    (dmem_dat_o & mask) !== (exp_data[checked] & mask)) begin
                    errors++;
                    $display("ERROR at %0t ns: store %0d got %h/%b/%h, expected %h/%b/%h",
                             $time, checked, dmem_adr_o, dmem_sel_o, dmem_dat_o,
                             exp_addr[checked], exp_sel[checked], exp_data[checked]);
                end
                checked++;
            end
        end
    end

    initial begin
        void'($urandom(51595));
        clk        = 1'b0;
        rst_i      = 1'b1;
        imem_dat_i = '0;
        imem_ack_i = 1'b0;
        dmem_dat_i = '0;
        dmem_ack_i = 1'b0;
        for (int i = 0; i < DMEM_BYTES; i++)
            dmem[i] = fill_byte(i);
        build_program();
        run_reference();
        limit = 40 * prog.size();
        repeat (10) begin
            @(negedge clk);
            if (imem_cyc_o !== 1'b0 || dmem_cyc_o !== 1'b0) begin
                errors++;
                $display("ERROR at %0t ns: bus cycle active during reset", $time);
            end
        end
        rst_i = 1'b0;
        while (checked < exp_addr.size() && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        if (checked < exp_addr.size()) begin
            errors++;
            $display("Timeout after %0d cycles, only %0d of %0d stores arrived",
                     cycles, checked, exp_addr.size());
        end else begin
            repeat (40) @(negedge clk); // Gives a repeated store time to show.
        end
        $display("Stores checked: %0d of %0d, errors: %0d", checked, exp_addr.size(), errors);
        if (errors == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule : tb_core

// File: files.f
source/rv32i_pkg.sv
source/inst_stream_if.sv
source/fetch_unit.sv
source/inst_queue.sv
source/execute_unit.sv
source/rv32i_core.sv
test/core_sva.sv
test/tb_core.sv

// File: run.sh
#!/bin/sh
# Builds tb_core with Verilator, runs it and checks the log.
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_core -Mdir obj_dir -o Vtb_core -f files.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vtb_core > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Verification failed" "$LOG"; then
    echo "Simulation reported errors, see $LOG"
    exit 1
fi
exit 0
